//--- design/ks10_cfg.svh
/*
 * Build-time sizes for the KS-10 memory subsystem
 * Memory depth, I/O register window, NXM timeout
 */

`ifndef KS10_CFG_SVH
`define KS10_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Memory
//////////////////////////////////////////////////////////////////////

// Implemented words, 32K
`define KS10_MEM_WORDS 32768
// Word index width, low bits of the 22-bit bus address
`define KS10_MEM_AW 15

//////////////////////////////////////////////////////////////////////
// I/O space and bus timing
//////////////////////////////////////////////////////////////////////

// I/O address of device register 0
`define KS10_IO_BASE 22'o0400000
`define KS10_IO_REGS 4
// Wait cycles before a cycle ends as NXM
`define KS10_NXM_TIMEOUT 16

`endif

//--- design/ks10BusPkg.sv
/*
 * Shared KS-10 bus types
 * PDP-10 word with full and halfword views, bus address
 */

package ks10BusPkg;

   //////////////////////////////////////////////////////////////////////
   // Address
   //////////////////////////////////////////////////////////////////////

   // PDP-10 numbering, bit 14 is the MSB and bit 35 the LSB
   typedef logic [14:35] ks10Addr_t;

   //////////////////////////////////////////////////////////////////////
   // Data word
   //////////////////////////////////////////////////////////////////////

   // One 36-bit word
   // Memory moves it whole, devices see left and right halves
   typedef union packed
   {
      logic [0:35] full;
      struct packed
      {
         // Left halfword, bits 0..17
         logic [0:17]  lh;
         // Right halfword, bits 18..35
         logic [18:35] rh;
      } half;
   } ks10Word_u;

endpackage

//--- design/ks10MemArray.sv
/*
 * KS-10 synchronous memory array
 * 32K words, acknowledges implemented addresses only
 */

`timescale 1ns/10ps
`include "ks10_cfg.svh"

module ks10MemArray
   import ks10BusPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Target handshake
   input  logic      memReq,
   input  logic      tgtWrite,
   input  ks10Addr_t tgtAddr,
   input  ks10Word_u tgtData,
   output ks10Word_u memData,
   output logic      memAck
);

   //////////////////////////////////////////////////////////////////////
   // Storage and decode
   //////////////////////////////////////////////////////////////////////

   // PDP-10 memory, big-endian bit numbering as on the real machine
   logic [0:35] ram [0:`KS10_MEM_WORDS-1];

   // Word index, low address bits only
   logic [0:`KS10_MEM_AW-1] memAddr;
   // Address falls inside the implemented 32K
   logic                    memHit;
   // First cycle of an accepted request
   logic                    memStart;

   assign memAddr  = tgtAddr[36-`KS10_MEM_AW:35];
   assign memHit   = (tgtAddr < `KS10_MEM_WORDS);
   assign memStart = memReq && memHit && !memAck;

   //////////////////////////////////////////////////////////////////////
   // Handshake
   //////////////////////////////////////////////////////////////////////

   // Ack one cycle after an implemented request
   // Missing memory never answers, controller times out
   always_ff @(posedge clk)
   begin
      if (rst)
         memAck <= 1'b0;
      else if (!memReq)
         memAck <= 1'b0;
      else if (memHit)
         memAck <= 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // RAM access
   //////////////////////////////////////////////////////////////////////

   // Write and read both happen on the accepting edge
   // Read word then stays put for the rest of the cycle
   always_ff @(posedge clk)
   begin
      if (memStart)
      begin
         if (tgtWrite)
            ram[memAddr] <= tgtData.full;
         // Write cycles echo the stored word
         memData.full <= tgtWrite ? tgtData.full : ram[memAddr];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Ack only ever answers a request seen on the previous edge
   memAckHasReq: assert property (@(posedge clk) disable iff (rst)
      $rose(memAck) |-> $past(memReq));

endmodule

//--- design/ks10IoRegs.sv
/*
 * KS-10 I/O register block
 * Four 18-bit device registers in I/O space, right halfword access
 */

`timescale 1ns/10ps
`include "ks10_cfg.svh"

module ks10IoRegs
   import ks10BusPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Target handshake
   input  logic      ioReq,
   input  logic      tgtWrite,
   input  ks10Addr_t tgtAddr,
   input  ks10Word_u tgtData,
   output ks10Word_u ioData,
   output logic      ioAck
);

   // Register select width
   localparam int ioIdxW = $clog2(`KS10_IO_REGS);

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////

   // Offset from register 0
   // Addresses below the base wrap high and miss
   ks10Addr_t          ioOffset;
   logic [ioIdxW-1:0]  ioIdx;
   logic               ioHit;
   // First cycle of an accepted request
   logic               ioStart;

   // Device registers, right halfword only
   logic [18:35] ioReg [0:`KS10_IO_REGS-1];

   assign ioOffset = tgtAddr - `KS10_IO_BASE;
   assign ioHit    = (ioOffset < `KS10_IO_REGS);
   assign ioIdx    = ioOffset[36-ioIdxW:35];
   assign ioStart  = ioReq && ioHit && !ioAck;

   //////////////////////////////////////////////////////////////////////
   // Handshake
   //////////////////////////////////////////////////////////////////////

   // Same timing as memory
   // Unowned addresses never ack
   always_ff @(posedge clk)
   begin
      if (rst)
         ioAck <= 1'b0;
      else if (!ioReq)
         ioAck <= 1'b0;
      else if (ioHit)
         ioAck <= 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////////////////////////

   // Device state, cleared on reset
   // Left half of a write is dropped
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < `KS10_IO_REGS; i++)
            ioReg[i] <= '0;
      end
      else if (ioStart && tgtWrite)
         ioReg[ioIdx] <= tgtData.half.rh;
   end

   // Read word, left half always zero
   always_ff @(posedge clk)
   begin
      if (ioStart)
      begin
         ioData.half.lh <= '0;
         // Write cycles echo the new value
         ioData.half.rh <= tgtWrite ? tgtData.half.rh : ioReg[ioIdx];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Release must be prompt so the controller can close the cycle
   ioAckRelease: assert property (@(posedge clk) disable iff (rst)
      $fell(ioReq) |=> !ioAck);

endmodule

//--- design/ks10BusCtrl.sv
/*
 * KS-10 bus controller
 * Processor four-phase handshake, memory/I/O steering,
 * NXM timeout and read data return
 */

`timescale 1ns/10ps
`include "ks10_cfg.svh"

module ks10BusCtrl
   import ks10BusPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Processor side
   input  logic      cpuReq,
   input  logic      cpuRead,
   input  logic      cpuWrite,
   input  logic      cpuIo,
   input  ks10Addr_t cpuAddr,
   input  ks10Word_u cpuData,
   output logic      cpuAck,
   output logic      cpuNxm,
   output ks10Word_u busData,
   // Target side
   output logic      memReq,
   output logic      ioReq,
   output logic      tgtWrite,
   output ks10Addr_t tgtAddr,
   output ks10Word_u tgtData,
   input  logic      memAck,
   input  logic      ioAck,
   input  ks10Word_u memData,
   input  ks10Word_u ioData
);

   //////////////////////////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////////////////////////

   // Wait counter must hold the full timeout value
   localparam int cntW = $clog2(`KS10_NXM_TIMEOUT + 1);

   // FSM encoding
   localparam logic [1:0] stIdle     = 2'd0;
   localparam logic [1:0] stRequest  = 2'd1;
   localparam logic [1:0] stComplete = 2'd2;
   localparam logic [1:0] stRelease  = 2'd3;

   logic [1:0]      state;
   // Cycle goes to I/O space
   logic            ioSel;
   logic [cntW-1:0] waitCnt;

   // Selected target
   logic            tgtAck;
   ks10Word_u       tgtRdata;

   // Events shared by control and payload paths
   logic            startCycle;
   logic            ackSeen;
   logic            timedOut;

   assign tgtAck   = ioSel ? ioAck : memAck;
   assign tgtRdata = ioSel ? ioData : memData;

   assign startCycle = (state == stIdle) && cpuReq;
   assign ackSeen    = (state == stRequest) && tgtAck;
   // Nobody claimed the address in time
   assign timedOut   = (state == stRequest) && !tgtAck &&
                       (waitCnt == cntW'(`KS10_NXM_TIMEOUT));

   //////////////////////////////////////////////////////////////////////
   // Handshake FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= stIdle;
         ioSel   <= 1'b0;
         waitCnt <= '0;
         memReq  <= 1'b0;
         ioReq   <= 1'b0;
         cpuAck  <= 1'b0;
         cpuNxm  <= 1'b0;
      end
      else
      begin
         case (state)
            // Steer by address space, one target only
            stIdle:
            begin
               if (startCycle)
               begin
                  memReq  <= !cpuIo;
                  ioReq   <= cpuIo;
                  ioSel   <= cpuIo;
                  waitCnt <= '0;
                  state   <= stRequest;
               end
            end
            // Count until ack or timeout
            stRequest:
            begin
               if (ackSeen || timedOut)
               begin
                  cpuAck <= 1'b1;
                  cpuNxm <= timedOut;
                  state  <= stComplete;
               end
               else
                  waitCnt <= waitCnt + 1'b1;
            end
            // Hold results until the processor lets go
            stComplete:
            begin
               if (!cpuReq)
               begin
                  memReq <= 1'b0;
                  ioReq  <= 1'b0;
                  state  <= stRelease;
               end
            end
            // Target must drop its ack first
            stRelease:
            begin
               if (!tgtAck)
               begin
                  cpuAck <= 1'b0;
                  cpuNxm <= 1'b0;
                  state  <= stIdle;
               end
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Payload
   //////////////////////////////////////////////////////////////////////

   // Latch request fields, return read word
   always_ff @(posedge clk)
   begin
      if (startCycle)
      begin
         tgtWrite <= cpuWrite && !cpuRead;
         tgtAddr  <= cpuAddr;
         tgtData  <= cpuData;
      end
      if (ackSeen)
         busData <= tgtRdata;
      else if (timedOut)
         busData <= '0;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   oneTarget: assert property (@(posedge clk) disable iff (rst)
      !(memReq && ioReq));

   rdWrExcl: assert property (@(posedge clk) disable iff (rst)
      cpuReq |-> !(cpuRead && cpuWrite));

   // Four-phase order on the processor side
   ackAfterReq: assert property (@(posedge clk) disable iff (rst)
      $fell(cpuAck) |-> !$past(cpuReq));

endmodule

//--- design/ks10MemSys.sv
/*
 * KS-10 memory subsystem top level
 * Bus controller, memory array and I/O registers
 */

`timescale 1ns/10ps

module ks10MemSys
   import ks10BusPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Processor side
   input  logic      cpuReq,
   input  logic      cpuRead,
   input  logic      cpuWrite,
   input  logic      cpuIo,
   input  ks10Addr_t cpuAddr,
   input  ks10Word_u cpuData,
   output logic      cpuAck,
   output logic      cpuNxm,
   output ks10Word_u busData
);

   //////////////////////////////////////////////////////////////////////
   // Target bus
   //////////////////////////////////////////////////////////////////////

   // Shared request fields
   logic      tgtWrite;
   ks10Addr_t tgtAddr;
   ks10Word_u tgtData;

   // Per-target handshake and read word
   logic      memReq;
   logic      memAck;
   ks10Word_u memData;
   logic      ioReq;
   logic      ioAck;
   ks10Word_u ioData;

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////

   ks10BusCtrl busCtrl (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .cpuRead  (cpuRead),
      .cpuWrite (cpuWrite),
      .cpuIo    (cpuIo),
      .cpuAddr  (cpuAddr),
      .cpuData  (cpuData),
      .cpuAck   (cpuAck),
      .cpuNxm   (cpuNxm),
      .busData  (busData),
      .memReq   (memReq),
      .ioReq    (ioReq),
      .tgtWrite (tgtWrite),
      .tgtAddr  (tgtAddr),
      .tgtData  (tgtData),
      .memAck   (memAck),
      .ioAck    (ioAck),
      .memData  (memData),
      .ioData   (ioData)
   );

   // Main memory
   ks10MemArray memArray (
      .clk      (clk),
      .rst      (rst),
      .memReq   (memReq),
      .tgtWrite (tgtWrite),
      .tgtAddr  (tgtAddr),
      .tgtData  (tgtData),
      .memData  (memData),
      .memAck   (memAck)
   );

   // Device registers
   ks10IoRegs ioRegs (
      .clk      (clk),
      .rst      (rst),
      .ioReq    (ioReq),
      .tgtWrite (tgtWrite),
      .tgtAddr  (tgtAddr),
      .tgtData  (tgtData),
      .ioData   (ioData),
      .ioAck    (ioAck)
   );

endmodule

//--- dv/tbKs10MemSys.sv
/*
 * Testbench for the KS-10 memory subsystem
 * Clock, reset, four-phase bus cycles, reference model, checks, timeout
 */

`timescale 1ns/10ps
`include "ks10_cfg.svh"

module tbKs10MemSys
   import ks10BusPkg::*;
();

   // Every bus cycle fits well inside this budget, even an NXM one
   localparam int cycleLimit = 300 * (`KS10_NXM_TIMEOUT + 10);

   logic      clk;
   logic      rst;
   logic      cpuReq;
   logic      cpuRead;
   logic      cpuWrite;
   logic      cpuIo;
   ks10Addr_t cpuAddr;
   ks10Word_u cpuData;
   logic      cpuAck;
   logic      cpuNxm;
   ks10Word_u busData;

   // Reference state
   ks10Word_u    modelMem [int];
   logic [18:35] modelIo [0:`KS10_IO_REGS-1];
   // Memory addresses that hold a known word
   int           writtenQ [$];

   // Results waiting for the checker
   ks10Word_u expWordQ [$];
   ks10Word_u gotWordQ [$];
   logic      expNxmQ [$];
   logic      gotNxmQ [$];
   logic      wordValidQ [$];
   event      resultReady;

   int          wordErrs = 0;
   int          flagErrs = 0;
   int          checkedCnt = 0;
   int          cycleCnt = 0;

   ks10MemSys dut_i (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .cpuRead  (cpuRead),
      .cpuWrite (cpuWrite),
      .cpuIo    (cpuIo),
      .cpuAddr  (cpuAddr),
      .cpuData  (cpuData),
      .cpuAck   (cpuAck),
      .cpuNxm   (cpuNxm),
      .busData  (busData)
   );

   //////////////////////////////////////////////////////////////////////
   // Clock and watchdog
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt >= cycleLimit)
      begin
         $display("Timeout: bus cycles did not finish within %0d clock cycles", cycleLimit);
         $display("Checked %0d cycles, %0d word errors, %0d flag errors",
                  checkedCnt, wordErrs, flagErrs);
         $display("TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic checkWord(input string name, input ks10Word_u expWord,
                            input ks10Word_u gotWord);
      if (gotWord !== expWord)
      begin
         wordErrs++;
         $display("FAIL t=%0t %s expected %012o got %012o",
                  $time, name, expWord.full, gotWord.full);
      end
   endtask

   task automatic checkFlag(input string name, input logic expFlag, input logic gotFlag);
      if (gotFlag !== expFlag)
      begin
         flagErrs++;
         $display("FAIL t=%0t %s expected %b got %b", $time, name, expFlag, gotFlag);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Word from two halves
   function automatic ks10Word_u makeWord(input logic [0:17] lh, input logic [18:35] rh);
      ks10Word_u w;
      w.half.lh = lh;
      w.half.rh = rh;
      return w;
   endfunction

   function automatic ks10Addr_t ioAddr(input int idx);
      return ks10Addr_t'(`KS10_IO_BASE + idx);
   endfunction

   // Expected read word and NXM flag
   // Model updated on writes
   // Memory owns 0..32K-1, devices own four words from the I/O base
   function automatic void refCycle(input logic write, input logic io, input ks10Addr_t addr,
                                    input ks10Word_u data, output ks10Word_u expWord,
                                    output logic expNxm);
      int unsigned a;
      int unsigned off;
      a       = addr;
      expWord = '0;
      expNxm  = 1'b1;
      if (io)
      begin
         if (a >= `KS10_IO_BASE && a < `KS10_IO_BASE + `KS10_IO_REGS)
         begin
            off    = a - `KS10_IO_BASE;
            expNxm = 1'b0;
            if (write)
               modelIo[off] = data.half.rh;
            expWord = makeWord('0, modelIo[off]);
         end
      end
      else if (a < `KS10_MEM_WORDS)
      begin
         expNxm = 1'b0;
         if (write)
            modelMem[a] = data;
         expWord = modelMem.exists(a) ? modelMem[a] : '0;
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus cycles
   //////////////////////////////////////////////////////////////////////

   // One four-phase cycle
   // Outputs sampled on the falling edge
   task automatic busCycle(input logic write, input logic io, input ks10Addr_t addr,
                           input ks10Word_u data, output ks10Word_u gotWord,
                           output logic gotNxm);
      @(posedge clk);
      #2;
      cpuRead  = !write;
      cpuWrite = write;
      cpuIo    = io;
      cpuAddr  = addr;
      cpuData  = data;
      cpuReq   = 1'b1;
      @(negedge clk);
      while (!cpuAck)
         @(negedge clk);
      gotWord = busData;
      gotNxm  = cpuNxm;
      @(posedge clk);
      #2;
      cpuReq = 1'b0;
      @(negedge clk);
      while (cpuAck)
         @(negedge clk);
   endtask

   // Predict, run, hand both to the checker
   task automatic runCycle(input logic write, input logic io, input ks10Addr_t addr,
                           input ks10Word_u data);
      ks10Word_u expWord;
      logic      expNxm;
      ks10Word_u gotWord;
      logic      gotNxm;
      refCycle(write, io, addr, data, expWord, expNxm);
      busCycle(write, io, addr, data, gotWord, gotNxm);
      expWordQ.push_back(expWord);
      gotWordQ.push_back(gotWord);
      expNxmQ.push_back(expNxm);
      gotNxmQ.push_back(gotNxm);
      // Data checked on reads and on every NXM
      wordValidQ.push_back(!write || expNxm);
      -> resultReady;
   endtask

   // Random memory traffic
   // Reads only hit written words
   task automatic memTraffic(input int count);
      ks10Addr_t   addr;
      ks10Word_u   data;
      logic [63:0] rnd;
      for (int i = 0; i < count; i++)
      begin
         rnd       = {$urandom, $urandom};
         data.full = rnd[35:0];
         if (writtenQ.size() == 0 || $urandom_range(1, 0) == 1)
         begin
            addr = ks10Addr_t'($urandom_range(`KS10_MEM_WORDS - 1, 0));
            writtenQ.push_back(addr);
            runCycle(1'b1, 1'b0, addr, data);
         end
         else
         begin
            addr = ks10Addr_t'(writtenQ[$urandom_range(writtenQ.size() - 1, 0)]);
            runCycle(1'b0, 1'b0, addr, data);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checker
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      ks10Word_u expW;
      ks10Word_u gotW;
      logic      expN;
      logic      gotN;
      logic      wordValid;
      forever
      begin
         while (gotNxmQ.size() > 0)
         begin
            expW      = expWordQ.pop_front();
            gotW      = gotWordQ.pop_front();
            expN      = expNxmQ.pop_front();
            gotN      = gotNxmQ.pop_front();
            wordValid = wordValidQ.pop_front();
            checkFlag("cpuNxm", expN, gotN);
            if (wordValid)
               checkWord("busData", expW, gotW);
            checkedCnt++;
         end
         @(resultReady);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(3));
      rst      = 1'b1;
      cpuReq   = 1'b0;
      cpuRead  = 1'b0;
      cpuWrite = 1'b0;
      cpuIo    = 1'b0;
      cpuAddr  = '0;
      cpuData  = '0;
      // Device registers come out of reset cleared
      for (int i = 0; i < `KS10_IO_REGS; i++)
         modelIo[i] = '0;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;

      // Quiet bus until the first request
      repeat (4)
      begin
         @(negedge clk);
         checkFlag("cpuAck", 1'b0, cpuAck);
         checkFlag("cpuNxm", 1'b0, cpuNxm);
      end

      // Write then read back word 5 and the last word
      runCycle(1'b1, 1'b0, 22'o0000005, makeWord(18'o123456, 18'o654321));
      runCycle(1'b0, 1'b0, 22'o0000005, '0);
      runCycle(1'b1, 1'b0, 22'o0077777, makeWord(18'o777777, 18'o000001));
      runCycle(1'b0, 1'b0, 22'o0077777, '0);
      writtenQ.push_back(5);
      writtenQ.push_back(32767);

      memTraffic(200);

      // Above the implemented 32K
      // Includes an alias of word 5
      runCycle(1'b0, 1'b0, ks10Addr_t'(`KS10_MEM_WORDS), '0);
      runCycle(1'b1, 1'b0, ks10Addr_t'(`KS10_MEM_WORDS + 5), makeWord(18'o707070, 18'o070707));
      runCycle(1'b0, 1'b0, 22'h3FFFFF, '0);
      runCycle(1'b1, 1'b0, `KS10_IO_BASE, makeWord(18'o000001, 18'o000002));
      for (int i = 0; i < 4; i++)
         runCycle(i[0], 1'b0, ks10Addr_t'($urandom_range(32'h3FFFFF, `KS10_MEM_WORDS)),
                  makeWord(18'o252525, 18'(i)));
      runCycle(1'b0, 1'b0, 22'o0000005, '0);

      // Device registers
      // Left half of writes dropped
      for (int i = 0; i < `KS10_IO_REGS; i++)
         runCycle(1'b0, 1'b1, ioAddr(i), '0);
      for (int i = 0; i < `KS10_IO_REGS; i++)
         runCycle(1'b1, 1'b1, ioAddr(i), makeWord(18'o777777 - 18'(i), 18'o100200 + 18'(i * 9)));
      for (int i = 0; i < `KS10_IO_REGS; i++)
         runCycle(1'b0, 1'b1, ioAddr(i), '0);
      memTraffic(20);
      for (int i = 0; i < `KS10_IO_REGS; i++)
         runCycle(1'b0, 1'b1, ioAddr(i), '0);

      // Unused I/O addresses and I/O cycles to memory addresses
      runCycle(1'b0, 1'b1, ioAddr(`KS10_IO_REGS), '0);
      runCycle(1'b1, 1'b1, ioAddr(`KS10_IO_REGS), makeWord(18'o111111, 18'o222222));
      runCycle(1'b0, 1'b1, ks10Addr_t'(`KS10_IO_BASE - 1), '0);
      runCycle(1'b0, 1'b1, 22'o0000005, '0);
      runCycle(1'b1, 1'b1, 22'o0000005, makeWord(18'o000001, 18'o000001));
      runCycle(1'b0, 1'b0, 22'o0000005, '0);
      runCycle(1'b0, 1'b1, ioAddr(0), '0);

      while (gotNxmQ.size() != 0)
         @(posedge clk);
      $display("Checked %0d cycles, %0d word errors, %0d flag errors",
               checkedCnt, wordErrs, flagErrs);
      if (wordErrs + flagErrs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+design
design/ks10BusPkg.sv
design/ks10MemArray.sv
design/ks10IoRegs.sv
design/ks10BusCtrl.sv
design/ks10MemSys.sv
dv/tbKs10MemSys.sv

//--- Bender.yml
package:
  name: ks10_mem_sys

sources:
  - include_dirs:
      - design
    files:
      - design/ks10BusPkg.sv
      - design/ks10MemArray.sv
      - design/ks10IoRegs.sv
      - design/ks10BusCtrl.sv
      - design/ks10MemSys.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tbKs10MemSys.sv
